// File: Bender.yml
package:
  name: sample_buffer

sources:
  - files:
      - rtl/sample_buffer_pkg.sv
      - rtl/sample_stream_if.sv
      - rtl/sample_buffer_bank.sv
      - rtl/capture_router.sv
      - rtl/readout_sequencer.sv
      - rtl/sample_buffer.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/sample_buffer_tb.sv

// File: project.f
+incdir+tb
rtl/sample_buffer_pkg.sv
rtl/sample_stream_if.sv
rtl/sample_buffer_bank.sv
rtl/capture_router.sv
rtl/readout_sequencer.sv
rtl/sample_buffer.sv
tb/sample_buffer_tb.sv

// File: rtl/capture_router.sv
// Capture control and input routing
`timescale 1ns/1ns
`default_nettype none

module capture_router import sample_buffer_pkg::*; #(
  parameter int CHANNELS = 4
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire mode_t           cfg_mode,
  input  wire                  cfg_valid,
  output logic                 cfg_ready,
  input  wire                  start,
  input  wire                  stop,
  input  wire sample_t         in_data [CHANNELS],
  input  wire [CHANNELS-1:0]   in_valid,
  output logic [CHANNELS-1:0]  in_ready,
  sample_stream_if.source      bank_wr [CHANNELS],
  input  wire [CHANNELS-1:0]   bank_full,
  output logic                 bank_clear,
  output logic                 capture_done,
  input  wire                  readout_done,
  output capture_state_t       state,
  output mode_t                mode,
  output logic                 capture_started,
  output logic                 buffer_full
);

  localparam int BW       = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
  localparam int MAX_MODE = $clog2(CHANNELS);

  logic [BW:0]          stride;
  logic [BW-1:0]        mask;
  logic [BW-1:0]        cursor [CHANNELS];
  logic [CHANNELS-1:0]  active;
  logic [CHANNELS-1:0]  cur_full;
  logic [CHANNELS-1:0]  at_last;
  logic                 full_hit;
  logic [BW-1:0]        owner [CHANNELS];
  logic                 bank_sel [CHANNELS];
  logic                 bank_ready [CHANNELS];

  assign stride     = (BW+1)'(1) << mode;
  assign mask       = stride[BW-1:0] - 1'b1;
  assign cfg_ready  = (state == IDLE);
  assign bank_clear = (state == IDLE) && start;

  // per channel view of its current bank
  always_comb begin
    full_hit = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      active[c]   = (BW+1)'(c) < stride;
      cur_full[c] = bank_full[cursor[c]];
      at_last[c]  = ({1'b0, cursor[c]} + stride) >= (BW+1)'(CHANNELS);
      in_ready[c] = (state == CAPTURE) && active[c] && bank_ready[cursor[c]];
      full_hit    = full_hit | (active[c] && cur_full[c] && at_last[c]);
    end
  end

  // bank b belongs to channel b mod 2**mode
  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    assign owner[b]    = BW'(b) & mask;
    assign bank_sel[b] = (state == CAPTURE) && active[owner[b]] &&
                         (cursor[owner[b]] == BW'(b));
    assign bank_wr[b].valid = bank_sel[b] && in_valid[owner[b]];
    assign bank_wr[b].data  = in_data[owner[b]];
    // write beats carry no framing
    assign bank_wr[b].last  = 1'b0;
    assign bank_ready[b]    = bank_wr[b].ready;
  end

  // cursor moves on to the channel's next bank once the current one is full
  always_ff @(posedge clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (reset || bank_clear) begin
        cursor[c] <= BW'(c);
      end else if ((state == CAPTURE) && active[c] && cur_full[c] && !at_last[c]) begin
        cursor[c] <= cursor[c] + stride[BW-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= IDLE;
      mode            <= '0;
      capture_done    <= 1'b0;
      capture_started <= 1'b0;
      buffer_full     <= 1'b0;
    end else begin
      capture_done <= 1'b0;
      case (state)
        IDLE: begin
          if (cfg_valid) begin
            // modes beyond the channel count fall back to one bank per channel
            mode <= (cfg_mode > mode_t'(MAX_MODE)) ? mode_t'(MAX_MODE) : cfg_mode;
          end
          if (start) begin
            state           <= CAPTURE;
            capture_started <= 1'b1;
            buffer_full     <= 1'b0;
          end
        end
        CAPTURE: begin
          if (stop || full_hit) begin
            state           <= READOUT;
            capture_done    <= 1'b1;
            capture_started <= 1'b0;
            buffer_full     <= full_hit;
          end
        end
        READOUT: begin
          if (readout_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/readout_sequencer.sv
// Bank readout sequencer
`timescale 1ns/1ns
`default_nettype none

module readout_sequencer import sample_buffer_pkg::*; #(
  parameter int CHANNELS = 4
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 capture_done,
  input  wire mode_t          mode,
  sample_stream_if.sink       bank_rd [CHANNELS],
  output logic [CHANNELS-1:0] rd_en,
  output sample_t             out_data,
  output logic                out_valid,
  input  wire                 out_ready,
  output logic                out_last,
  output logic                readout_done
);

  localparam int BW = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  capture_state_t seq_state;
  logic [BW-1:0]  bank_idx;
  logic           fwd;
  logic           drain;
  logic [BW:0]    stride;
  logic [BW-1:0]  owner;
  logic           load;
  logic           walking;
  logic           take;
  logic           final_bank;
  sample_t        bank_data [CHANNELS];
  logic           bank_valid [CHANNELS];
  logic           bank_last [CHANNELS];

  // every bank has an owning channel in every mode and none is skipped
  assign stride     = (BW+1)'(1) << mode;
  assign owner      = bank_idx & (stride[BW-1:0] - 1'b1);
  assign final_bank = (bank_idx == BW'(CHANNELS - 1));
  assign load       = !out_valid || out_ready;
  assign walking    = (seq_state == READOUT) && !drain;
  assign take       = walking && fwd && load && bank_valid[bank_idx];

  always_comb begin
    for (int b = 0; b < CHANNELS; b++) begin
      rd_en[b] = walking && fwd && (bank_idx == BW'(b));
    end
  end

  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    assign bank_rd[b].ready = rd_en[b] && load;
    assign bank_data[b]     = bank_rd[b].data;
    assign bank_valid[b]    = bank_rd[b].valid;
    assign bank_last[b]     = bank_rd[b].last;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      seq_state    <= IDLE;
      bank_idx     <= '0;
      fwd          <= 1'b0;
      drain        <= 1'b0;
      out_valid    <= 1'b0;
      out_last     <= 1'b0;
      readout_done <= 1'b0;
    end else begin
      readout_done <= 1'b0;
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      case (seq_state)
        IDLE: begin
          if (capture_done) begin
            seq_state <= READOUT;
            bank_idx  <= '0;
            fwd       <= 1'b0;
            drain     <= 1'b0;
          end
        end
        READOUT: begin
          if (drain) begin
            // wait for the final word to leave
            if (out_valid && out_ready) begin
              seq_state    <= IDLE;
              drain        <= 1'b0;
              out_last     <= 1'b0;
              readout_done <= 1'b1;
            end
          end else if (!fwd) begin
            if (load) begin
              out_valid <= 1'b1;
              out_last  <= 1'b0;
              fwd       <= 1'b1;
            end
          end else if (take) begin
            out_valid <= 1'b1;
            out_last  <= bank_last[bank_idx] && final_bank;
            if (bank_last[bank_idx]) begin
              fwd <= 1'b0;
              if (final_bank) begin
                drain <= 1'b1;
              end else begin
                bank_idx <= bank_idx + 1'b1;
              end
            end
          end
        end
        default: seq_state <= IDLE;
      endcase
    end
  end

  // channel word ahead of each bank and then the bank's own words
  always_ff @(posedge clk) begin
    if (walking && !fwd && load) begin
      out_data <= sample_t'(owner);
    end else if (take) begin
      out_data <= bank_data[bank_idx];
    end
  end

endmodule

`default_nettype wire

// File: rtl/sample_buffer.sv
// Banked capture buffer
`timescale 1ns/1ns
`default_nettype none

module sample_buffer import sample_buffer_pkg::*; #(
  parameter int CHANNELS     = 4,
  parameter int BUFFER_DEPTH = 64
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire sample_t        in_data [CHANNELS],
  input  wire [CHANNELS-1:0]  in_valid,
  output wire [CHANNELS-1:0]  in_ready,
  output wire sample_t        out_data,
  output wire                 out_valid,
  input  wire                 out_ready,
  output wire                 out_last,
  input  wire mode_t          cfg_mode,
  input  wire                 cfg_valid,
  output wire                 cfg_ready,
  input  wire                 start,
  input  wire                 stop,
  output wire                 capture_started,
  output wire                 buffer_full
);

  // the memory is split evenly across the banks
  localparam int BANK_DEPTH = BUFFER_DEPTH / CHANNELS;

  wire [CHANNELS-1:0] bank_full;
  wire [CHANNELS-1:0] rd_en;
  wire                bank_clear;
  wire                capture_done;
  wire                readout_done;
  wire mode_t         mode;

  sample_stream_if bank_wr [CHANNELS] ();
  sample_stream_if bank_rd [CHANNELS] ();

  capture_router #(
    .CHANNELS(CHANNELS)
  ) u_router (
    .clk,
    .reset,
    .cfg_mode,
    .cfg_valid,
    .cfg_ready,
    .start,
    .stop,
    .in_data,
    .in_valid,
    .in_ready,
    .bank_wr         (bank_wr),
    .bank_full,
    .bank_clear,
    .capture_done,
    .readout_done,
    .state           (),
    .mode,
    .capture_started,
    .buffer_full
  );

  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    sample_buffer_bank #(
      .DEPTH(BANK_DEPTH)
    ) u_bank (
      .clk,
      .reset,
      .clear (bank_clear),
      .wr    (bank_wr[b]),
      .full  (bank_full[b]),
      .rd_en (rd_en[b]),
      .rd    (bank_rd[b])
    );
  end

  readout_sequencer #(
    .CHANNELS(CHANNELS)
  ) u_sequencer (
    .clk,
    .reset,
    .capture_done,
    .mode,
    .bank_rd      (bank_rd),
    .rd_en,
    .out_data,
    .out_valid,
    .out_ready,
    .out_last,
    .readout_done
  );

endmodule

`default_nettype wire

// File: rtl/sample_buffer_bank.sv
// Capture buffer bank
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_bank import sample_buffer_pkg::*; #(
  parameter int DEPTH = 16
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  clear,
  sample_stream_if.sink wr,
  output logic full,
  input  wire  rd_en,
  sample_stream_if.source rd
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // wide enough for the count word index plus DEPTH samples
  localparam int CW = $clog2(DEPTH + 2);

  sample_t       mem [DEPTH];
  sample_t       mem_q;
  sample_t       wr_data_q;
  logic          wr_pend;
  logic [AW-1:0] wr_ptr;
  logic [CW-1:0] count;

  logic [CW-1:0] rd_idx;
  logic [CW-1:0] rd_idx_m1;
  logic          issue;
  logic          fire;
  logic          out_load;
  logic [1:0]    occ;
  logic          s1_valid;
  logic          s1_count;
  logic          s1_last;
  sample_t       s1_data;
  logic          skid_valid;
  logic          skid_last;
  sample_t       skid_data;

  assign full     = (count == CW'(DEPTH));
  assign wr.ready = !full;

  // count tracks accepted beats and the write lands a cycle later
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count   <= '0;
      wr_ptr  <= '0;
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= wr.valid && wr.ready;
      if (wr.valid && wr.ready) begin
        count <= count + 1'b1;
      end
      if (wr_pend) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr.valid && wr.ready) begin
      wr_data_q <= wr.data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_pend) begin
      mem[wr_ptr] <= wr_data_q;
    end
    mem_q <= mem[rd_idx_m1[AW-1:0]];
  end

  // readout index 0 is the count word and index k reads sample k-1
  assign rd_idx_m1 = rd_idx - 1'b1;
  assign s1_data   = s1_count ? sample_t'(count) : mem_q;
  assign fire      = rd.valid && rd.ready;
  assign out_load  = !rd.valid || rd.ready;

  // at most two words held after this cycle ever wait for the sink
  assign occ   = 2'(rd.valid) + 2'(skid_valid) + 2'(s1_valid) - 2'(fire);
  assign issue = rd_en && (rd_idx <= count) && (occ < 2'd2);

  always_ff @(posedge clk) begin
    if (reset || !rd_en) begin
      rd_idx     <= '0;
      s1_valid   <= 1'b0;
      skid_valid <= 1'b0;
      rd.valid   <= 1'b0;
    end else begin
      if (issue) begin
        rd_idx <= rd_idx + 1'b1;
      end
      s1_valid <= issue;
      if (out_load) begin
        if (skid_valid) begin
          rd.valid   <= 1'b1;
          skid_valid <= s1_valid;
        end else begin
          rd.valid <= s1_valid;
        end
      end else if (s1_valid) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      s1_count <= (rd_idx == '0);
      s1_last  <= (rd_idx == count);
    end
    if (out_load) begin
      rd.data <= skid_valid ? skid_data : s1_data;
      rd.last <= skid_valid ? skid_last : s1_last;
    end
    // prefetch register catches the word in flight under back-pressure
    if ((out_load && skid_valid) || (!out_load && s1_valid)) begin
      skid_data <= s1_data;
      skid_last <= s1_last;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sample_buffer_pkg.sv
// Sample buffer types
`default_nettype none

package sample_buffer_pkg;

  // largest channel count the banking mode can describe
  localparam int MAX_CHANNELS = 8;

  // one sample word, which also carries the channel and count words on readout
  typedef logic [15:0] sample_t;

  // banking mode m enables channels 0 to 2**m - 1
  typedef logic [$clog2(MAX_CHANNELS)-1:0] mode_t;

  typedef enum logic [1:0] {
    IDLE,
    CAPTURE,
    READOUT
  } capture_state_t;

endpackage

`default_nettype wire

// File: rtl/sample_stream_if.sv
// Sample stream interface
`timescale 1ns/1ns
`default_nettype none

interface sample_stream_if import sample_buffer_pkg::*; ();

  sample_t data;
  logic    valid;
  logic    ready;
  logic    last;

  // data and last hold while valid is high and ready is low
  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: tb/sample_buffer_tb_tasks.svh
// Sample buffer testbench tasks
`ifndef SAMPLE_BUFFER_TB_TASKS_SVH
`define SAMPLE_BUFFER_TB_TASKS_SVH

task automatic check_sample(input sample_t got, input sample_t exp, input string what);
  if (got !== exp) begin
    sample_errors++;
    $display("ERR %0t ns %s: got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_count(input sample_t got, input sample_t exp, input string what);
  if (got !== exp) begin
    count_errors++;
    $display("ERR %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    flag_errors++;
    $display("ERR %0t ns %s: got %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic configure(input mode_t m);
  @(posedge clk);
  cfg_mode  <= m;
  cfg_valid <= 1'b1;
  do @(negedge clk); while (!cfg_ready);
  @(posedge clk);
  cfg_valid <= 1'b0;
  cur_mode = m;
endtask

task automatic start_capture();
  do @(negedge clk); while (!cfg_ready);
  @(posedge clk);
  start <= 1'b1;
  @(posedge clk);
  start <= 1'b0;
  @(negedge clk);
  check_flag(capture_started, 1'b1, "capture_started after start");
  check_flag(buffer_full, 1'b0, "buffer_full after start");
  check_flag(cfg_ready, 1'b0, "cfg_ready during capture");
endtask

// offers n_req samples per channel and records the accepted ones
task automatic send_samples(input sample_t base, input bit toggle);
  int idx [CHANNELS];
  bit taken [CHANNELS];
  bit busy;
  for (int c = 0; c < CHANNELS; c++) begin
    idx[c]   = 0;
    taken[c] = 1'b0;
    sent_q[c].delete();
  end
  busy = 1'b1;
  while (busy) begin
    @(posedge clk);
    for (int c = 0; c < CHANNELS; c++) begin
      if (!in_valid[c] || taken[c]) begin
        in_valid[c] <= (idx[c] < n_req[c]) && (!toggle || (($random(seed) & 1) != 0));
        in_data[c]  <= base + sample_t'((c << 8) + idx[c]);
      end
    end
    @(negedge clk);
    busy = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      taken[c] = in_valid[c] && in_ready[c];
      if (taken[c]) begin
        sent_q[c].push_back(in_data[c]);
        idx[c]++;
      end
      if (c >= (1 << cur_mode)) begin
        check_flag(in_ready[c], 1'b0, "in_ready of a disabled channel");
      end
      if (idx[c] < n_req[c]) begin
        busy = 1'b1;
      end
    end
    if (!capture_started) begin
      busy = 1'b0;
    end
  end
  @(posedge clk);
  in_valid <= '0;
endtask

task automatic end_capture(input bit use_stop, input logic exp_full);
  if (use_stop) begin
    @(posedge clk);
    stop <= 1'b1;
    @(posedge clk);
    stop <= 1'b0;
  end
  do @(negedge clk); while (capture_started);
  check_flag(buffer_full, exp_full, "buffer_full at end of capture");
  check_flag(|in_ready, 1'b0, "in_ready after capture");
endtask

// gathers readout words until out_last and checks that stalled words hold
task automatic read_out(input bit random_ready);
  sample_t held_data;
  logic    held_last;
  bit      stalled;
  bit      done;
  rx_data.delete();
  rx_last.delete();
  stalled = 1'b0;
  done    = 1'b0;
  while (!done) begin
    @(posedge clk);
    out_ready <= !random_ready || (($random(seed) & 1) != 0);
    @(negedge clk);
    if (stalled) begin
      check_flag(out_valid, 1'b1, "out_valid held while stalled");
      check_sample(out_data, held_data, "out_data held while stalled");
      check_flag(out_last, held_last, "out_last held while stalled");
    end
    stalled   = out_valid && !out_ready;
    held_data = out_data;
    held_last = out_last;
    if (out_valid && out_ready) begin
      rx_data.push_back(out_data);
      rx_last.push_back(out_last);
      done = out_last;
    end
  end
  @(posedge clk);
  out_ready <= 1'b0;
endtask

// bank b belongs to channel b mod 2**mode and is that channel's k-th bank
task automatic check_readout();
  int owners;
  int pos;
  int ch;
  int k;
  int cnt;
  owners = 1 << cur_mode;
  pos    = 0;
  for (int b = 0; b < CHANNELS; b++) begin
    if (pos + 2 > rx_data.size()) begin
      other_errors++;
      $display("readout stopped before the words of bank %0d", b);
      return;
    end
    ch  = b % owners;
    k   = b / owners;
    cnt = sent_q[ch].size() - k * D;
    if (cnt < 0) begin
      cnt = 0;
    end
    if (cnt > D) begin
      cnt = D;
    end
    check_count(rx_data[pos], sample_t'(ch), "channel word");
    check_count(rx_data[pos + 1], sample_t'(cnt), "count word");
    for (int j = 0; j < int'(rx_data[pos + 1]) && pos + 2 + j < rx_data.size(); j++) begin
      if (k * D + j < sent_q[ch].size()) begin
        check_sample(rx_data[pos + 2 + j], sent_q[ch][k * D + j], "stored sample");
      end else begin
        check_sample(rx_data[pos + 2 + j], 'x, "sample beyond those sent");
      end
    end
    pos += 2 + int'(rx_data[pos + 1]);
  end
  if (pos != rx_data.size()) begin
    other_errors++;
    $display("readout had %0d words where its count words add up to %0d", rx_data.size(), pos);
  end
  for (int i = 0; i < rx_last.size(); i++) begin
    check_flag(rx_last[i], i == rx_last.size() - 1, "out_last");
  end
endtask

`endif

// File: tb/sample_buffer_tb.sv
// Sample buffer testbench
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_tb import sample_buffer_pkg::*; ();

  localparam int CHANNELS     = 4;
  localparam int BUFFER_DEPTH = 64;
  localparam int D            = BUFFER_DEPTH / CHANNELS;
  // worst case of one capture covers setup, toggled input and readout at half rate
  localparam int CAPTURE_CYCLES = 40 + 4 * BUFFER_DEPTH + 4 * (BUFFER_DEPTH + 2 * CHANNELS);
  localparam int NUM_CAPTURES   = 11;
  localparam int TIMEOUT_CYCLES = 2 * NUM_CAPTURES * CAPTURE_CYCLES;

  logic                clk;
  logic                reset;
  sample_t             in_data [CHANNELS];
  logic [CHANNELS-1:0] in_valid;
  logic [CHANNELS-1:0] in_ready;
  sample_t             out_data;
  logic                out_valid;
  logic                out_ready;
  logic                out_last;
  mode_t               cfg_mode;
  logic                cfg_valid;
  logic                cfg_ready;
  logic                start;
  logic                stop;
  logic                capture_started;
  logic                buffer_full;

  integer  seed = 32'h28b3_a304;
  int      cycles = 0;
  int      sample_errors = 0;
  int      count_errors = 0;
  int      flag_errors = 0;
  int      other_errors = 0;
  mode_t   cur_mode;
  int      n_req [CHANNELS];
  sample_t sent_q [CHANNELS][$];
  sample_t rx_data [$];
  logic    rx_last [$];
  sample_t ref_data [$];

  sample_buffer #(
    .CHANNELS     (CHANNELS),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) i_dut (.*);

  `include "sample_buffer_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // a few samples per active channel in each mode
  task automatic test_modes();
    for (int m = 0; m < 3; m++) begin
      configure(mode_t'(m));
      for (int c = 0; c < CHANNELS; c++) begin
        n_req[c] = (c < (1 << m)) ? 3 + 2 * c : 0;
      end
      start_capture();
      send_samples(16'h1000, 1'b0);
      end_capture(1'b1, 1'b0);
      read_out(1'b0);
      check_readout();
    end
  endtask

  // every active channel filled exactly to its share of the memory
  task automatic test_fill();
    for (int m = 0; m < 3; m++) begin
      configure(mode_t'(m));
      for (int c = 0; c < CHANNELS; c++) begin
        n_req[c] = (c < (1 << m)) ? BUFFER_DEPTH >> m : 0;
      end
      start_capture();
      send_samples(16'h2000, 1'b0);
      end_capture(1'b0, 1'b1);
      read_out(1'b0);
      check_readout();
    end
  endtask

  // channel 0 runs out of room while the others are still sending
  task automatic test_early_full();
    configure(mode_t'(2));
    n_req = '{40, 12, 5, 14};
    start_capture();
    send_samples(16'h3000, 1'b1);
    end_capture(1'b0, 1'b1);
    check_count(sample_t'(sent_q[0].size()), sample_t'(D), "samples taken by channel 0");
    read_out(1'b0);
    check_readout();
  endtask

  task automatic test_back_pressure();
    configure(mode_t'(1));
    n_req = '{20, 9, 0, 0};
    start_capture();
    send_samples(16'h4000, 1'b0);
    end_capture(1'b1, 1'b0);
    read_out(1'b0);
    check_readout();
    ref_data = rx_data;
    start_capture();
    send_samples(16'h4000, 1'b0);
    end_capture(1'b1, 1'b0);
    read_out(1'b1);
    check_readout();
    if (rx_data.size() != ref_data.size()) begin
      other_errors++;
      $display("stalled readout gave %0d words, steady readout gave %0d",
               rx_data.size(), ref_data.size());
    end
    for (int i = 0; i < rx_data.size() && i < ref_data.size(); i++) begin
      check_sample(rx_data[i], ref_data[i], "stalled readout word");
    end
  endtask

  task automatic test_control();
    configure(mode_t'(1));
    n_req = '{3, 0, 0, 0};
    start_capture();
    send_samples(16'h5000, 1'b0);
    // a second start must neither restart nor clear the banks
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_flag(capture_started, 1'b1, "capture_started after second start");
    check_flag(cfg_ready, 1'b0, "cfg_ready after second start");
    end_capture(1'b1, 1'b0);
    read_out(1'b0);
    check_readout();
    configure(mode_t'(0));
    n_req = '{0, 0, 0, 0};
    start_capture();
    send_samples(16'h6000, 1'b0);
    end_capture(1'b1, 1'b0);
    read_out(1'b0);
    check_readout();
  endtask

  initial begin
    reset     = 1'b1;
    in_valid  = '0;
    out_ready = 1'b0;
    cfg_mode  = '0;
    cfg_valid = 1'b0;
    start     = 1'b0;
    stop      = 1'b0;
    cur_mode  = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      in_data[c] = '0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag(cfg_ready, 1'b1, "cfg_ready after reset");
    check_flag(|in_ready, 1'b0, "in_ready after reset");
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(out_last, 1'b0, "out_last after reset");
    check_flag(capture_started, 1'b0, "capture_started after reset");
    check_flag(buffer_full, 1'b0, "buffer_full after reset");
    test_modes();
    test_fill();
    test_early_full();
    test_back_pressure();
    test_control();
    $display("errors: %0d sample, %0d count, %0d flag, %0d other",
             sample_errors, count_errors, flag_errors, other_errors);
    if (sample_errors + count_errors + flag_errors + other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
